// ==== rv_dec_params.svh ====
`ifndef RV_DEC_PARAMS_SVH
`define RV_DEC_PARAMS_SVH

// Data word width
`define RV_XLEN 32

// Register index width
`define RV_REG_W 5

// Major opcode width
`define RV_OPC_W 7

// funct3 width
`define RV_F3_W 3

`endif

// ==== rv_isa_pkg.sv ====
`default_nettype none

`include "rv_dec_params.svh"

package rv_isa_pkg;

	typedef enum logic [`RV_OPC_W-1:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		SYSTEM = 7'b1110011
	} opcode_e;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

	typedef struct packed {
		logic [6:0]           funct7;
		logic [`RV_REG_W-1:0] rs2;
		logic [`RV_REG_W-1:0] rs1;
		logic [`RV_F3_W-1:0]  funct3;
		logic [`RV_REG_W-1:0] rd;
		logic [`RV_OPC_W-1:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]          imm;
		logic [`RV_REG_W-1:0] rs1;
		logic [`RV_F3_W-1:0]  funct3;
		logic [`RV_REG_W-1:0] rd;
		logic [`RV_OPC_W-1:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]           imm_hi;
		logic [`RV_REG_W-1:0] rs2;
		logic [`RV_REG_W-1:0] rs1;
		logic [`RV_F3_W-1:0]  funct3;
		logic [4:0]           imm_lo;
		logic [`RV_OPC_W-1:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic                 imm12;
		logic [5:0]           imm10_5;
		logic [`RV_REG_W-1:0] rs2;
		logic [`RV_REG_W-1:0] rs1;
		logic [`RV_F3_W-1:0]  funct3;
		logic [3:0]           imm4_1;
		logic                 imm11;
		logic [`RV_OPC_W-1:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0]          imm;
		logic [`RV_REG_W-1:0] rd;
		logic [`RV_OPC_W-1:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic                 imm20;
		logic [9:0]           imm10_1;
		logic                 imm11;
		logic [7:0]           imm19_12;
		logic [`RV_REG_W-1:0] rd;
		logic [`RV_OPC_W-1:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} insn_u;

endpackage

`default_nettype wire

// ==== rv_dec_pkg.sv ====
`default_nettype none

`include "rv_dec_params.svh"

package rv_dec_pkg;

	typedef enum logic [5:0] {
		LUI,
		AUIPC,
		JAL,
		JALR,
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU,
		LB,
		LH,
		LW,
		LBU,
		LHU,
		SB,
		SH,
		SW,
		ADDI,
		SLTI,
		SLTIU,
		XORI,
		ORI,
		ANDI,
		SLLI,
		SRLI,
		SRAI,
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		ECALL_EBREAK,
		ILLEGAL
	} dec_op_e;

	typedef struct packed {
		dec_op_e              op;
		logic [`RV_REG_W-1:0] rd;
		logic [`RV_REG_W-1:0] rs1;
		logic [`RV_REG_W-1:0] rs2;
		logic                 rd_we;
		logic [`RV_XLEN-1:0]  imm;
		logic                 illegal;
	} dec_rec_t;

endpackage

`default_nettype wire

// ==== op_class_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_dec_params.svh"

interface op_class_if;

	logic                 s1_valid;
	rv_dec_pkg::dec_op_e  op;
	logic [`RV_REG_W-1:0] rd;
	logic [`RV_REG_W-1:0] rs1;
	logic [`RV_REG_W-1:0] rs2;
	logic                 illegal;

	modport producer (
		output s1_valid, op, rd, rs1, rs2, illegal
	);

	modport consumer (
		input s1_valid, op, rd, rs1, rs2, illegal
	);

endinterface

`default_nettype wire

// ==== op_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_classifier (
	input  logic               clk,
	input  logic               resetn,
	input  logic               advance,
	input  rv_isa_pkg::insn_u  insn,
	op_class_if.producer       cls,
	input  logic               s2_take
);

	rv_dec_pkg::dec_op_e op_next;
	logic [2:0] f3;
	logic [6:0] f7;
	logic f7_base;
	logic f7_alt;

	assign f3 = insn.r_fmt.funct3;
	assign f7 = insn.r_fmt.funct7;
	assign f7_base = f7 == rv_isa_pkg::F7_BASE;
	assign f7_alt = f7 == rv_isa_pkg::F7_ALT;

	always_comb begin
		op_next = rv_dec_pkg::ILLEGAL;
		case (insn.r_fmt.opcode)
			rv_isa_pkg::LUI:   op_next = rv_dec_pkg::LUI;
			rv_isa_pkg::AUIPC: op_next = rv_dec_pkg::AUIPC;
			rv_isa_pkg::JAL:   op_next = rv_dec_pkg::JAL;
			rv_isa_pkg::JALR: begin
				if (f3 == 3'b000)
					op_next = rv_dec_pkg::JALR;
			end
			rv_isa_pkg::BRANCH: begin
				case (f3)
					3'b000: op_next = rv_dec_pkg::BEQ;
					3'b001: op_next = rv_dec_pkg::BNE;
					3'b100: op_next = rv_dec_pkg::BLT;
					3'b101: op_next = rv_dec_pkg::BGE;
					3'b110: op_next = rv_dec_pkg::BLTU;
					3'b111: op_next = rv_dec_pkg::BGEU;
					default: op_next = rv_dec_pkg::ILLEGAL;
				endcase
			end
			rv_isa_pkg::LOAD: begin
				case (f3)
					3'b000: op_next = rv_dec_pkg::LB;
					3'b001: op_next = rv_dec_pkg::LH;
					3'b010: op_next = rv_dec_pkg::LW;
					3'b100: op_next = rv_dec_pkg::LBU;
					3'b101: op_next = rv_dec_pkg::LHU;
					default: op_next = rv_dec_pkg::ILLEGAL;
				endcase
			end
			rv_isa_pkg::STORE: begin
				case (f3)
					3'b000: op_next = rv_dec_pkg::SB;
					3'b001: op_next = rv_dec_pkg::SH;
					3'b010: op_next = rv_dec_pkg::SW;
					default: op_next = rv_dec_pkg::ILLEGAL;
				endcase
			end
			rv_isa_pkg::OP_IMM: begin
				case (f3)
					3'b000: op_next = rv_dec_pkg::ADDI;
					3'b010: op_next = rv_dec_pkg::SLTI;
					3'b011: op_next = rv_dec_pkg::SLTIU;
					3'b100: op_next = rv_dec_pkg::XORI;
					3'b110: op_next = rv_dec_pkg::ORI;
					3'b111: op_next = rv_dec_pkg::ANDI;
					3'b001: if (f7_base) op_next = rv_dec_pkg::SLLI;
					default: begin // Shift right
						if (f7_base)
							op_next = rv_dec_pkg::SRLI;
						else if (f7_alt)
							op_next = rv_dec_pkg::SRAI;
					end
				endcase
			end
			rv_isa_pkg::OP: begin
				if (f7_base) begin
					case (f3)
						3'b000: op_next = rv_dec_pkg::ADD;
						3'b001: op_next = rv_dec_pkg::SLL;
						3'b010: op_next = rv_dec_pkg::SLT;
						3'b011: op_next = rv_dec_pkg::SLTU;
						3'b100: op_next = rv_dec_pkg::XOR;
						3'b101: op_next = rv_dec_pkg::SRL;
						3'b110: op_next = rv_dec_pkg::OR;
						default: op_next = rv_dec_pkg::AND;
					endcase
				end else if (f7_alt && f3 == 3'b000) begin
					op_next = rv_dec_pkg::SUB;
				end else if (f7_alt && f3 == 3'b101) begin
					op_next = rv_dec_pkg::SRA;
				end
			end
			rv_isa_pkg::SYSTEM: begin
				// Bit 20 alone picks ECALL or EBREAK
				if (insn.i_fmt.imm[11:1] == '0 && insn.i_fmt.rs1 == '0 && f3 == 3'b000 &&
						insn.i_fmt.rd == '0)
					op_next = rv_dec_pkg::ECALL_EBREAK;
			end
			default: op_next = rv_dec_pkg::ILLEGAL;
		endcase
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			cls.op <= op_next;
			cls.illegal <= op_next == rv_dec_pkg::ILLEGAL;
			cls.rd <= insn.r_fmt.rd;
			cls.rs1 <= insn.r_fmt.rs1;
			cls.rs2 <= insn.r_fmt.rs2;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			cls.s1_valid <= 1'b0;
		else if (advance)
			cls.s1_valid <= 1'b1;
		else if (s2_take)
			cls.s1_valid <= 1'b0; // Moved on to stage two
	end

	// A stalled word in stage one is never overwritten
	a_s1_hold: assert property (@(posedge clk) disable iff (!resetn)
		cls.s1_valid && !s2_take |-> !advance);

endmodule

`default_nettype wire

// ==== imm_extractor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_dec_params.svh"

module imm_extractor (
	input  logic                clk,
	input  logic                advance,
	input  rv_isa_pkg::insn_u   insn,
	output logic [`RV_XLEN-1:0] s1_imm
);

	logic [`RV_XLEN-1:0] imm_next;

	always_comb begin
		case (insn.r_fmt.opcode)
			rv_isa_pkg::JALR,
			rv_isa_pkg::LOAD,
			rv_isa_pkg::OP_IMM: begin
				// Shift amounts stay in the I view
				imm_next = {{(`RV_XLEN-12){insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
			end
			rv_isa_pkg::STORE: begin
				imm_next = {{(`RV_XLEN-12){insn.s_fmt.imm_hi[6]}},
					insn.s_fmt.imm_hi, insn.s_fmt.imm_lo};
			end
			rv_isa_pkg::BRANCH: begin
				imm_next = {{(`RV_XLEN-13){insn.b_fmt.imm12}}, insn.b_fmt.imm12,
					insn.b_fmt.imm11, insn.b_fmt.imm10_5, insn.b_fmt.imm4_1, 1'b0};
			end
			rv_isa_pkg::LUI,
			rv_isa_pkg::AUIPC: begin
				imm_next = {insn.u_fmt.imm, 12'b0}; // Upper 20 bits
			end
			rv_isa_pkg::JAL: begin
				imm_next = {{(`RV_XLEN-21){insn.j_fmt.imm20}}, insn.j_fmt.imm20,
					insn.j_fmt.imm19_12, insn.j_fmt.imm11, insn.j_fmt.imm10_1, 1'b0};
			end
			default: imm_next = '0; // R-type, SYSTEM, unknown
		endcase
	end

	always_ff @(posedge clk) begin
		if (advance)
			s1_imm <= imm_next;
	end

endmodule

`default_nettype wire

// ==== decode_combiner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_dec_params.svh"

module decode_combiner (
	input  logic                   clk,
	input  logic                   resetn,
	op_class_if.consumer           cls,
	input  logic [`RV_XLEN-1:0]    s1_imm,
	input  logic                   in_valid,
	output logic                   in_ready,
	output logic                   advance,
	output logic                   s2_take,
	output logic                   out_valid,
	input  logic                   out_ready,
	output rv_dec_pkg::dec_rec_t   out_rec
);

	rv_dec_pkg::dec_rec_t rec_next;
	logic run;
	logic writes_rd;
	logic load;

	assign s2_take = !out_valid || out_ready;
	assign in_ready = run && (!cls.s1_valid || s2_take);
	assign advance = in_valid && in_ready;
	assign load = cls.s1_valid && s2_take;

	always_comb begin
		case (cls.op)
			rv_dec_pkg::BEQ, rv_dec_pkg::BNE, rv_dec_pkg::BLT,
			rv_dec_pkg::BGE, rv_dec_pkg::BLTU, rv_dec_pkg::BGEU,
			rv_dec_pkg::SB, rv_dec_pkg::SH, rv_dec_pkg::SW,
			rv_dec_pkg::ECALL_EBREAK, rv_dec_pkg::ILLEGAL:
				writes_rd = 1'b0;
			default:
				writes_rd = 1'b1;
		endcase
	end

	always_comb begin
		rec_next.op = cls.op;
		rec_next.illegal = cls.illegal;
		rec_next.rd = cls.illegal ? '0 : cls.rd;
		rec_next.rs1 = cls.illegal ? '0 : cls.rs1;
		rec_next.rs2 = cls.illegal ? '0 : cls.rs2;
		rec_next.imm = cls.illegal ? '0 : s1_imm;
		rec_next.rd_we = writes_rd && cls.rd != '0; // x0 is never written
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			run <= 1'b0; // Input held off until out of reset
			out_valid <= 1'b0;
		end else begin
			run <= 1'b1;
			if (s2_take)
				out_valid <= cls.s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			out_rec <= rec_next;
	end

	a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
		out_valid && !out_ready |=> out_valid && $stable(out_rec));

endmodule

`default_nettype wire

// ==== rv32i_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_dec_params.svh"

module rv32i_decoder (
	input  logic                  clk,
	input  logic                  resetn,

	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [`RV_XLEN-1:0]   in_insn,

	output logic                  out_valid,
	input  logic                  out_ready,
	output rv_dec_pkg::dec_op_e   out_op,
	output logic [`RV_REG_W-1:0]  out_rd,
	output logic [`RV_REG_W-1:0]  out_rs1,
	output logic [`RV_REG_W-1:0]  out_rs2,
	output logic                  out_rd_we,
	output logic [`RV_XLEN-1:0]   out_imm,
	output logic                  out_illegal
);

	rv_isa_pkg::insn_u insn;
	rv_dec_pkg::dec_rec_t out_rec;
	logic [`RV_XLEN-1:0] s1_imm;
	logic advance;
	logic s2_take;

	op_class_if cls ();

	assign insn = in_insn;

	op_classifier u_classifier (
		.clk     (clk),
		.resetn  (resetn),
		.advance (advance),
		.insn    (insn),
		.cls     (cls.producer),
		.s2_take (s2_take)
	);

	imm_extractor u_extractor (
		.clk     (clk),
		.advance (advance),
		.insn    (insn),
		.s1_imm  (s1_imm)
	);

	decode_combiner u_combiner (
		.clk       (clk),
		.resetn    (resetn),
		.cls       (cls.consumer),
		.s1_imm    (s1_imm),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.advance   (advance),
		.s2_take   (s2_take),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rec   (out_rec)
	);

	assign out_op = out_rec.op;
	assign out_rd = out_rec.rd;
	assign out_rs1 = out_rec.rs1;
	assign out_rs2 = out_rec.rs2;
	assign out_rd_we = out_rec.rd_we;
	assign out_imm = out_rec.imm;
	assign out_illegal = out_rec.illegal;

endmodule

`default_nettype wire

// ==== tb_rv32i_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_dec_params.svh"

module tb_rv32i_decoder;

	localparam int TIMEOUT = 200;
	localparam int NUM_TEMPLATES = 45; // 44 and up give a fully random word
	localparam int NUM_RANDOM = 400;

	logic clk = 1'b0;
	logic resetn;
	logic in_valid;
	logic in_ready;
	logic [`RV_XLEN-1:0] in_insn;
	logic out_valid;
	logic out_ready;
	rv_dec_pkg::dec_op_e out_op;
	logic [`RV_REG_W-1:0] out_rd;
	logic [`RV_REG_W-1:0] out_rs1;
	logic [`RV_REG_W-1:0] out_rs2;
	logic out_rd_we;
	logic [`RV_XLEN-1:0] out_imm;
	logic out_illegal;

	integer seed = 81739;
	int errors = 0;
	int checked = 0;
	int sent = 0;
	int cycle = 0;
	int last_acc = 0;
	int stretch = 0;
	bit abort = 0;
	bit fixed_ready = 1;
	bit hold_pending = 0;
	logic [31:0] ready_rnd;
	rv_dec_pkg::dec_rec_t held;

	rv_dec_pkg::dec_rec_t exp_q[$];
	int acc_q[$];
	bit dir_q[$];

	rv32i_decoder UUT (
		.clk         (clk),
		.resetn      (resetn),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_insn     (in_insn),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_op      (out_op),
		.out_rd      (out_rd),
		.out_rs1     (out_rs1),
		.out_rs2     (out_rs2),
		.out_rd_we   (out_rd_we),
		.out_imm     (out_imm),
		.out_illegal (out_illegal)
	);

	always #2 clk = ~clk;

	always @(negedge clk) cycle++; // Stable at every rising edge

	// Expected record straight from the RV32I encoding tables
	function automatic rv_dec_pkg::dec_rec_t expect_rec(input logic [31:0] w);
		rv_dec_pkg::dec_rec_t e;
		logic [6:0] opc;
		logic [6:0] f7;
		logic [2:0] f3;
		logic [31:0] imm_i;
		opc = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		imm_i = {{20{w[31]}}, w[31:20]};
		e.op = rv_dec_pkg::ILLEGAL;
		e.imm = '0;
		case (opc)
			7'h37: begin
				e.op = rv_dec_pkg::LUI;
				e.imm = {w[31:12], 12'h000};
			end
			7'h17: begin
				e.op = rv_dec_pkg::AUIPC;
				e.imm = {w[31:12], 12'h000};
			end
			7'h6f: begin
				e.op = rv_dec_pkg::JAL;
				e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			7'h67: begin
				if (f3 == 3'd0)
					e.op = rv_dec_pkg::JALR;
				e.imm = imm_i;
			end
			7'h63: begin
				case (f3)
					3'd0: e.op = rv_dec_pkg::BEQ;
					3'd1: e.op = rv_dec_pkg::BNE;
					3'd4: e.op = rv_dec_pkg::BLT;
					3'd5: e.op = rv_dec_pkg::BGE;
					3'd6: e.op = rv_dec_pkg::BLTU;
					3'd7: e.op = rv_dec_pkg::BGEU;
					default: e.op = rv_dec_pkg::ILLEGAL;
				endcase
				e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			end
			7'h03: begin
				case (f3)
					3'd0: e.op = rv_dec_pkg::LB;
					3'd1: e.op = rv_dec_pkg::LH;
					3'd2: e.op = rv_dec_pkg::LW;
					3'd4: e.op = rv_dec_pkg::LBU;
					3'd5: e.op = rv_dec_pkg::LHU;
					default: e.op = rv_dec_pkg::ILLEGAL;
				endcase
				e.imm = imm_i;
			end
			7'h23: begin
				case (f3)
					3'd0: e.op = rv_dec_pkg::SB;
					3'd1: e.op = rv_dec_pkg::SH;
					3'd2: e.op = rv_dec_pkg::SW;
					default: e.op = rv_dec_pkg::ILLEGAL;
				endcase
				e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
			end
			7'h13: begin
				case (f3)
					3'd0: e.op = rv_dec_pkg::ADDI;
					3'd2: e.op = rv_dec_pkg::SLTI;
					3'd3: e.op = rv_dec_pkg::SLTIU;
					3'd4: e.op = rv_dec_pkg::XORI;
					3'd6: e.op = rv_dec_pkg::ORI;
					3'd7: e.op = rv_dec_pkg::ANDI;
					3'd1: e.op = (f7 == 7'h00) ? rv_dec_pkg::SLLI : rv_dec_pkg::ILLEGAL;
					default: begin
						if (f7 == 7'h00)
							e.op = rv_dec_pkg::SRLI;
						else if (f7 == 7'h20)
							e.op = rv_dec_pkg::SRAI;
					end
				endcase
				e.imm = imm_i;
			end
			7'h33: begin
				case ({f7, f3})
					{7'h00, 3'd0}: e.op = rv_dec_pkg::ADD;
					{7'h20, 3'd0}: e.op = rv_dec_pkg::SUB;
					{7'h00, 3'd1}: e.op = rv_dec_pkg::SLL;
					{7'h00, 3'd2}: e.op = rv_dec_pkg::SLT;
					{7'h00, 3'd3}: e.op = rv_dec_pkg::SLTU;
					{7'h00, 3'd4}: e.op = rv_dec_pkg::XOR;
					{7'h00, 3'd5}: e.op = rv_dec_pkg::SRL;
					{7'h20, 3'd5}: e.op = rv_dec_pkg::SRA;
					{7'h00, 3'd6}: e.op = rv_dec_pkg::OR;
					{7'h00, 3'd7}: e.op = rv_dec_pkg::AND;
					default: e.op = rv_dec_pkg::ILLEGAL;
				endcase
			end
			7'h73: begin
				// Only ECALL and EBREAK, CSR forms fall through as illegal
				if (w[31:21] == 11'd0 && w[19:7] == 13'd0)
					e.op = rv_dec_pkg::ECALL_EBREAK;
			end
			default: e.op = rv_dec_pkg::ILLEGAL;
		endcase
		e.illegal = (e.op == rv_dec_pkg::ILLEGAL);
		e.rd = e.illegal ? 5'd0 : w[11:7];
		e.rs1 = e.illegal ? 5'd0 : w[19:15];
		e.rs2 = e.illegal ? 5'd0 : w[24:20];
		if (e.illegal)
			e.imm = '0;
		e.rd_we = !e.illegal && opc != 7'h63 && opc != 7'h23 && opc != 7'h73 &&
			w[11:7] != 5'd0;
		return e;
	endfunction

	// Word of template t with random fields
	function automatic logic [31:0] make_word(input int t);
		logic [31:0] r;
		logic [31:0] w;
		logic [2:0] f3;
		logic [6:0] f7;
		r = $random(seed);
		if (t == 0)
			w = {r[31:7], 7'h37};
		else if (t == 1)
			w = {r[31:7], 7'h17};
		else if (t == 2)
			w = {r[31:7], 7'h6f};
		else if (t == 3)
			w = {r[31:15], 3'd0, r[11:7], 7'h67};
		else if (t < 10) begin
			f3 = (t < 6) ? 3'(t - 4) : 3'(t - 2);
			w = {r[31:15], f3, r[11:7], 7'h63};
		end else if (t < 15) begin
			f3 = (t < 13) ? 3'(t - 10) : 3'(t - 9);
			w = {r[31:15], f3, r[11:7], 7'h03};
		end else if (t < 18) begin
			w = {r[31:15], 3'(t - 15), r[11:7], 7'h23};
		end else if (t < 24) begin
			f3 = (t == 18) ? 3'd0 : (t < 22) ? 3'(t - 17) : 3'(t - 16);
			w = {r[31:15], f3, r[11:7], 7'h13};
		end else if (t < 27) begin // SLLI, SRLI, SRAI
			f7 = (t == 26) ? 7'h20 : 7'h00;
			f3 = (t == 24) ? 3'd1 : 3'd5;
			w = {f7, r[24:15], f3, r[11:7], 7'h13};
		end else if (t < 37) begin
			f7 = (t == 28 || t == 34) ? 7'h20 : 7'h00;
			f3 = (t <= 28) ? 3'd0 : (t <= 33) ? 3'(t - 28) : 3'(t - 29);
			w = {f7, r[24:15], f3, r[11:7], 7'h33};
		end else if (t == 37)
			w = 32'h00000073;
		else if (t == 38)
			w = 32'h00100073;
		else if (t == 39) // Shift with a bad funct7
			w = {r[31:25] | 7'h01, r[24:15], r[14] ? 3'd1 : 3'd5, r[11:7], 7'h13};
		else if (t == 40)
			w = {r[31:25] | 7'h01, r[24:7], 7'h33};
		else if (t == 41) // CSR access
			w = {r[31:15], r[14:13], 1'b1, r[11:7], 7'h73};
		else if (t == 42) // FENCE
			w = {r[31:15], 3'd0, r[11:7], 7'h0f};
		else if (t == 43)
			w = {r[31:7], 7'h0b};
		else
			w = r;
		return w;
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	// Call on a falling edge, returns on the falling edge after the transfer
	task automatic send_word(input logic [31:0] w, input bit directed);
		int waited;
		bit done;
		in_valid = 1'b1;
		in_insn = w;
		waited = 0;
		done = 0;
		while (!done && !abort) begin
			@(posedge clk);
			if (in_ready) begin
				done = 1;
			end else begin
				waited++;
				if (waited > TIMEOUT) begin
					$display("Timeout: in_ready stayed low for %0d cycles", TIMEOUT);
					errors++;
					abort = 1;
				end
			end
		end
		if (done) begin
			exp_q.push_back(expect_rec(w));
			acc_q.push_back(cycle);
			dir_q.push_back(directed);
			if (directed && sent > 0 && cycle != last_acc + 1) begin
				$display("Back-to-back words were not accepted on consecutive cycles");
				errors++;
			end
			last_acc = cycle;
			sent++;
		end
		@(negedge clk);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && !abort) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				$display("Timeout: %0d decoded words never left the output", exp_q.size());
				errors++;
				abort = 1;
			end
		end
	endtask

	// Random stretches of back-pressure
	always @(negedge clk) begin
		if (fixed_ready) begin
			out_ready = 1'b1;
		end else if (stretch == 0) begin
			ready_rnd = $random(seed);
			out_ready = ready_rnd[0];
			stretch = int'(ready_rnd[10:8]);
		end else begin
			stretch--;
		end
	end

	always @(posedge clk) begin : compare
		rv_dec_pkg::dec_rec_t got;
		rv_dec_pkg::dec_rec_t e;
		int acc;
		bit dir;
		got = {out_op, out_rd, out_rs1, out_rs2, out_rd_we, out_imm, out_illegal};
		if (resetn) begin
			if (hold_pending && !out_valid) begin
				$display("out_valid dropped while out_ready was low");
				errors++;
			end else if (hold_pending && got !== held) begin
				$display("Output record changed while out_ready was low");
				errors++;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("Output transfer with no word pending");
					errors++;
				end else begin
					e = exp_q.pop_front();
					acc = acc_q.pop_front();
					dir = dir_q.pop_front();
					check_field("out_op", 32'(got.op), 32'(e.op));
					check_field("out_rd", 32'(got.rd), 32'(e.rd));
					check_field("out_rs1", 32'(got.rs1), 32'(e.rs1));
					check_field("out_rs2", 32'(got.rs2), 32'(e.rs2));
					check_field("out_rd_we", 32'(got.rd_we), 32'(e.rd_we));
					check_field("out_imm", got.imm, e.imm);
					check_field("out_illegal", 32'(got.illegal), 32'(e.illegal));
					if (dir && cycle != acc + 2) begin
						$display("Word accepted at cycle %0d left at cycle %0d", acc, cycle);
						errors++;
					end
					checked++;
				end
			end
			hold_pending = out_valid && !out_ready;
			held = got;
		end else begin
			hold_pending = 0;
		end
	end

	initial begin
		resetn = 1'b0;
		in_valid = 1'b0;
		in_insn = '0;
		out_ready = 1'b0;
		repeat (4) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		if (out_valid !== 1'b0) begin
			$display("out_valid is not low after reset");
			errors++;
		end
		// Every template once, back to back with the output always ready
		for (int t = 0; t < NUM_TEMPLATES && !abort; t++)
			send_word(make_word(t), 1'b1);
		in_valid = 1'b0;
		wait_drain();
		fixed_ready = 0;
		for (int i = 0; i < NUM_RANDOM && !abort; i++) begin
			if ({$random(seed)} % 4 == 0) begin
				in_valid = 1'b0;
				@(negedge clk);
			end
			send_word(make_word(int'({$random(seed)} % 46)), 1'b0);
		end
		in_valid = 1'b0;
		wait_drain();
		$display("Sent %0d words, checked %0d, %0d errors", sent, checked, errors);
		if (errors == 0 && checked == sent)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rv32i_decoder.f ====
+incdir+.
rv_isa_pkg.sv
rv_dec_pkg.sv
op_class_if.sv
op_classifier.sv
imm_extractor.sv
decode_combiner.sv
rv32i_decoder.sv
tb_rv32i_decoder.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f rv32i_decoder.f \
	--top-module tb_rv32i_decoder \
	-o sim_rv32i_decoder

./obj_dir/sim_rv32i_decoder > sim.log 2>&1 || true
cat sim.log

if grep -q -F '*** FAILED ***' sim.log || ! grep -q -F '*** PASSED ***' sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
